// File: zports.f
+incdir+common
+incdir+tests
common/zports_pkg.sv
rtl/bus_strobes.sv
rtl/port_decode.sv
regs/config_regs.sv
regs/ulaplus_regs.sv
rtl/sd_port.sv
rtl/read_mux.sv
rtl/zports.sv
tests/tb_zports.sv

// File: tests/zports_vectors.svh
/*
 * zports test table
 * one z80 io cycle per row, expected read data and register state after it
 */
`ifndef ZPORTS_VECTORS_SVH
`define ZPORTS_VECTORS_SVH

localparam logic OP_RD = 1'b0;
localparam logic OP_WR = 1'b1;

// where the expected read byte comes from
localparam logic [2:0] RD_NONE  = 3'd0;
localparam logic [2:0] RD_CONST = 3'd1;  // rexp column
localparam logic [2:0] RD_KJ    = 3'd2;
localparam logic [2:0] RD_MOUSE = 3'd3;
localparam logic [2:0] RD_KEYS  = 3'd4;  // 1, tape, 0, keys
localparam logic [2:0] RD_SDBUF = 3'd5;  // byte latched by the last sd access

// state checked one cycle after the bus is released
localparam logic [3:0] CK_NONE   = 4'd0;
localparam logic [3:0] CK_EVO    = 4'd1;  // evo_cfg, romrw_en
localparam logic [3:0] CK_PAGE   = 4'd2;  // p7ffd, pent1m_page, pent1m_rom
localparam logic [3:0] CK_EFF7   = 4'd3;  // peff7, pent1m_1m_on, pent1m_ram0_0
localparam logic [3:0] CK_ATM    = 4'd4;
localparam logic [3:0] CK_BORDER = 4'd5;  // border, beeper pulse
localparam logic [3:0] CK_SDWR   = 4'd6;
localparam logic [3:0] CK_SDRD   = 4'd7;
localparam logic [3:0] CK_PALSEL = 4'd8;
localparam logic [3:0] CK_PALWR  = 4'd9;
localparam logic [3:0] CK_UPENA  = 4'd10;
localparam logic [3:0] CK_COVOX  = 4'd11; // covox pulse
localparam logic [3:0] CK_NMI    = 4'd12; // clr_nmi pulse
localparam logic [3:0] CK_SDCS   = 4'd13; // chip-select strobe and value

// op, address, data, dos, raster, {external_port, porthit}, read source,
// read value, check, check value, second check value
task automatic load_table();
	// xxBF config, bit 2 dropped
	add_row(OP_WR, 16'h00BF, 8'h3E, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_EVO,    8'h0F, 8'h00);
	add_row(OP_RD, 16'h00BF, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h3A, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h00BF, 8'h20, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_EVO,    8'h01, 8'h00);
	add_row(OP_RD, 16'h00BF, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h20, CK_NONE,   8'h00, 8'h00);
	// paging and its locks
	add_row(OP_WR, 16'h7FFD, 8'hD3, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_PAGE,   8'hD3, 8'h73);
	add_row(OP_RD, 16'h0ABD, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'hD3, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'hEFF7, 8'h0C, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_EFF7,   8'h00, 8'h02);
	add_row(OP_RD, 16'h0BBD, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h0C, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h7FFD, 8'h25, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_PAGE,   8'h05, 8'h0D);
	add_row(OP_WR, 16'h7FFD, 8'h07, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_PAGE,   8'h05, 8'h0D);
	add_row(OP_RD, 16'h0ABD, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h25, CK_NONE,   8'h00, 8'h00);
	// shadow dependent decode
	add_row(OP_RD, 16'h001F, 8'h00, 0, 2'd0, 2'b01, RD_KJ,    8'h00, CK_NONE,   8'h00, 8'h00);
	add_row(OP_RD, 16'h003F, 8'h00, 1, 2'd0, 2'b11, RD_CONST, 8'hFF, CK_NONE,   8'h00, 8'h00);
	add_row(OP_RD, 16'h00FE, 8'h00, 0, 2'd0, 2'b01, RD_KEYS,  8'h00, CK_NONE,   8'h00, 8'h00);
	add_row(OP_RD, 16'h00DF, 8'h00, 0, 2'd0, 2'b01, RD_MOUSE, 8'h00, CK_NONE,   8'h00, 8'h00);
	add_row(OP_RD, 16'h0001, 8'h00, 0, 2'd0, 2'b00, RD_CONST, 8'hFF, CK_NONE,   8'h00, 8'h00);
	// atm xx77, shadow only
	add_row(OP_WR, 16'h0377, 8'h0D, 1, 2'd0, 2'b01, RD_NONE,  8'h00, CK_ATM,    8'h5B, 8'h00);
	add_row(OP_RD, 16'h0CBD, 8'h00, 1, 2'd0, 2'b01, RD_CONST, 8'h7D, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h4077, 8'h02, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_ATM,    8'h5B, 8'h00);
	add_row(OP_RD, 16'h0CBD, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h6D, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h4077, 8'h02, 1, 2'd0, 2'b01, RD_NONE,  8'h00, CK_ATM,    8'h24, 8'h00);
	// sd card
	add_row(OP_RD, 16'h0077, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h00, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h0077, 8'h02, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_SDCS,   8'h01, 8'h00);
	add_row(OP_WR, 16'h0057, 8'hA5, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_SDWR,   8'hA5, 8'h00);
	add_row(OP_RD, 16'h0057, 8'h00, 0, 2'd0, 2'b01, RD_SDBUF, 8'h00, CK_SDRD,   8'h00, 8'h00);
	add_row(OP_RD, 16'h0057, 8'h00, 0, 2'd0, 2'b01, RD_SDBUF, 8'h00, CK_SDRD,   8'h00, 8'h00);
	// border and beeper, covox, nmi end
	add_row(OP_WR, 16'h00FE, 8'h05, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_BORDER, 8'h05, 8'h01);
	add_row(OP_WR, 16'h00F6, 8'h02, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_BORDER, 8'h0A, 8'h00);
	add_row(OP_RD, 16'h0FBD, 8'h00, 0, 2'd0, 2'b01, RD_CONST, 8'h0A, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'h00FB, 8'h80, 0, 2'd0, 2'b00, RD_NONE,  8'h00, CK_COVOX,  8'h00, 8'h00);
	add_row(OP_WR, 16'h00BE, 8'h00, 0, 2'd0, 2'b01, RD_NONE,  8'h00, CK_NMI,    8'h00, 8'h00);
	// ulaplus, 128k raster only
	add_row(OP_RD, 16'hFF3B, 8'h00, 0, 2'd0, 2'b00, RD_CONST, 8'hFF, CK_NONE,   8'h00, 8'h00);
	add_row(OP_WR, 16'hBF3B, 8'h15, 0, 2'd3, 2'b01, RD_NONE,  8'h00, CK_PALSEL, 8'h15, 8'h00);
	add_row(OP_WR, 16'hFF3B, 8'hB9, 0, 2'd3, 2'b01, RD_NONE,  8'h00, CK_PALWR,  8'hD5, 8'h00);
	add_row(OP_WR, 16'hBF3B, 8'h40, 0, 2'd3, 2'b01, RD_NONE,  8'h00, CK_PALSEL, 8'h15, 8'h00);
	add_row(OP_WR, 16'hFF3B, 8'h01, 0, 2'd3, 2'b01, RD_NONE,  8'h00, CK_UPENA,  8'h01, 8'h00);
	add_row(OP_RD, 16'hFF3B, 8'h00, 0, 2'd3, 2'b01, RD_CONST, 8'h01, CK_NONE,   8'h00, 8'h00);
endtask

`endif

// File: tests/tb_zports.sv
/*
 * zports testbench
 * runs the io cycle table against the port block and checks reads and state
 */
`timescale 1ns/1ns
`default_nettype none

module tb_zports import zports_pkg::*; ();

	logic        fclk, rst_n, zpos;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n, rd_n, wr_n, dos;
	logic [1:0]  modes_raster;
	logic        tape_read;
	logic [4:0]  keys_in;
	logic [7:0]  kj_in, mus_in, sd_dataout;

	logic [7:0]  dout;
	logic        dataout, porthit, external_port;
	logic [3:0]  border;
	evo_cfg_t    evo_cfg;
	atm_cfg_t    atm_cfg;
	logic [7:0]  p7ffd, peff7;
	logic        pent1m_rom;
	logic [5:0]  pent1m_page;
	logic        pent1m_1m_on, pent1m_ram0_0, romrw_en;
	logic        beeper_wr, covox_wr, clr_nmi;
	logic        sd_cs_n_val, sd_cs_n_stb, sd_start;
	logic [7:0]  sd_datain;
	logic        up_ena;
	logic [5:0]  up_paladdr;
	logic [7:0]  up_paldata;
	logic        up_palwr;

	typedef struct packed
	{
		logic        op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic        dos;
		logic [1:0]  raster;
		logic [1:0]  hit;    // {external_port, porthit}
		logic [2:0]  rsrc;
		logic [7:0]  rexp;
		logic [3:0]  chk;
		logic [7:0]  cexp;
		logic [7:0]  cexp2;
	} row_t;

	row_t       table_q[$];
	int         cycle_cnt = 0;
	int         cycle_limit = 0;  // set once the table is loaded
	int         fail_count = 0;
	int         cur_row = -1;
	logic [7:0] sd_model = 8'hFF; // spi byte the DUT should hold
	logic       seen_beep, seen_start, seen_pal;
	logic       seen_covox, seen_nmi, seen_cs, cs_cap;
	logic [7:0] sd_din_cap, pal_cap;

	`include "zports_vectors.svh"

	zports dut_i (.*);

	initial fclk = 1'b0;
	always #50 fclk = ~fclk;

	// run length guard
	always @(posedge fclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit)
		begin
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

	task automatic add_row(input logic op, input logic [15:0] addr, input logic [7:0] data,
	                       input logic dos_v, input logic [1:0] raster, input logic [1:0] hit,
	                       input logic [2:0] rsrc, input logic [7:0] rexp,
	                       input logic [3:0] chk, input logic [7:0] cexp,
	                       input logic [7:0] cexp2);
		table_q.push_back({op, addr, data, dos_v, raster, hit, rsrc, rexp, chk, cexp, cexp2});
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
	                               input logic [15:0] exp);
		fail_count++;
		$display("Fail %s: got 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_event(input string msg);
		fail_count++;
		$display("Error in row %0d: %s", cur_row, msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// read byte the port should return, from the inputs driven this row
	function automatic logic [7:0] expected_read(input row_t r);
		case (r.rsrc)
			RD_KJ:    return kj_in;
			RD_MOUSE: return mus_in;
			RD_KEYS:  return {1'b1, tape_read, 1'b0, keys_in};
			RD_SDBUF: return sd_model;
			default:  return r.rexp;
		endcase
	endfunction

	task automatic check_reset();
		assert (atm_cfg == 7'b0110100) else report_mismatch("atm_cfg", atm_cfg, 7'b0110100);
		assert (evo_cfg == 5'h00) else report_mismatch("evo_cfg", evo_cfg, 5'h00);
		assert (p7ffd == 8'h00) else report_mismatch("p7ffd", p7ffd, 8'h00);
		assert (peff7 == 8'h00) else report_mismatch("peff7", peff7, 8'h00);
		assert (up_ena == 1'b0) else report_mismatch("up_ena", up_ena, 1'b0);
		assert ({beeper_wr, covox_wr, clr_nmi, sd_cs_n_stb, sd_start, up_palwr} == 6'b0)
			else report_event("a strobe output is high after reset");
	endtask

	// combinational outputs, early in the bus cycle
	task automatic check_live(input row_t r);
		logic exp_dataout;
		exp_dataout = (r.op == OP_RD) && r.hit[0] && !r.hit[1];
		assert (porthit == r.hit[0]) else report_mismatch("porthit", porthit, r.hit[0]);
		assert (external_port == r.hit[1])
			else report_mismatch("external_port", external_port, r.hit[1]);
		assert (dataout == exp_dataout) else report_mismatch("dataout", dataout, exp_dataout);
		if (r.op == OP_RD)
			assert (dout == expected_read(r)) else report_mismatch("dout", dout, expected_read(r));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// state after the cycle
	task automatic check_after(input row_t r);
		case (r.chk)
			CK_EVO:
			begin
				assert (evo_cfg == r.cexp[4:0]) else report_mismatch("evo_cfg", evo_cfg, r.cexp[4:0]);
				assert (romrw_en == r.cexp[3]) else report_mismatch("romrw_en", romrw_en, r.cexp[3]);
			end
			CK_PAGE:
			begin
				assert (p7ffd == r.cexp) else report_mismatch("p7ffd", p7ffd, r.cexp);
				assert (pent1m_page == r.cexp2[5:0])
					else report_mismatch("pent1m_page", pent1m_page, r.cexp2[5:0]);
				assert (pent1m_rom == r.cexp2[6])
					else report_mismatch("pent1m_rom", pent1m_rom, r.cexp2[6]);
			end
			CK_EFF7:
			begin
				assert (peff7 == r.cexp) else report_mismatch("peff7", peff7, r.cexp);
				assert (pent1m_1m_on == r.cexp2[0])
					else report_mismatch("pent1m_1m_on", pent1m_1m_on, r.cexp2[0]);
				assert (pent1m_ram0_0 == r.cexp2[1])
					else report_mismatch("pent1m_ram0_0", pent1m_ram0_0, r.cexp2[1]);
			end
			CK_ATM:
				assert (atm_cfg == r.cexp[6:0]) else report_mismatch("atm_cfg", atm_cfg, r.cexp[6:0]);
			CK_BORDER:
			begin
				assert (border == r.cexp[3:0]) else report_mismatch("border", border, r.cexp[3:0]);
				assert (seen_beep == r.cexp2[0])
					else report_event("beeper_wr pulse does not match the port written");
			end
			CK_SDWR, CK_SDRD:
			begin
				assert (seen_start) else report_event("sd_start did not pulse on the SDDAT access");
				assert (sd_din_cap == ((r.chk == CK_SDRD) ? 8'hFF : r.cexp))
					else report_mismatch("sd_datain", sd_din_cap,
					                     (r.chk == CK_SDRD) ? 8'hFF : r.cexp);
			end
			CK_PALSEL:
			begin
				assert (up_paladdr == r.cexp[5:0])
					else report_mismatch("up_paladdr", up_paladdr, r.cexp[5:0]);
				assert (!seen_pal) else report_event("up_palwr pulsed on a select port write");
			end
			CK_PALWR:
			begin
				assert (seen_pal) else report_event("up_palwr did not pulse on a palette write");
				assert (pal_cap == r.cexp) else report_mismatch("up_paldata", pal_cap, r.cexp);
			end
			CK_UPENA:
				assert (up_ena == r.cexp[0]) else report_mismatch("up_ena", up_ena, r.cexp[0]);
			CK_COVOX:
				assert (seen_covox) else report_event("covox_wr did not pulse on the FB write");
			CK_NMI:
				assert (seen_nmi) else report_event("clr_nmi did not pulse on the BE write");
			CK_SDCS:
			begin
				assert (seen_cs) else report_event("sd_cs_n_stb did not pulse on the SDCFG write");
				assert (cs_cap == r.cexp[0]) else report_mismatch("sd_cs_n_val", cs_cap, r.cexp[0]);
			end
			default: ;
		endcase
	endtask

	// one z80 io cycle, bus active 6 fclk, then released
	task automatic apply_row(input row_t r);
		logic [31:0] rnd;
		int          i;
		@(negedge fclk);
		rnd          = $urandom;
		keys_in      = rnd[4:0];
		tape_read    = rnd[5];
		kj_in        = rnd[15:8];
		mus_in       = rnd[23:16];
		sd_dataout   = rnd[31:24];
		a            = r.addr;
		din          = r.data;
		dos          = r.dos;
		modes_raster = r.raster;
		iorq_n       = 1'b0;
		rd_n         = r.op;   // write rows keep rd_n high
		wr_n         = ~r.op;
		seen_beep    = 1'b0;
		seen_start   = 1'b0;
		seen_pal     = 1'b0;
		seen_covox   = 1'b0;
		seen_nmi     = 1'b0;
		seen_cs      = 1'b0;
		for (i = 0; i < 6; i++)
		begin
			@(negedge fclk);
			if (i == 0)
				check_live(r);   // before the pulse touches sd_buf
			if (beeper_wr)
				seen_beep = 1'b1;
			if (covox_wr)
				seen_covox = 1'b1;
			if (clr_nmi)
				seen_nmi = 1'b1;
			if (sd_cs_n_stb)
			begin
				seen_cs = 1'b1;
				cs_cap  = sd_cs_n_val;
			end
			if (sd_start)
			begin
				seen_start = 1'b1;
				sd_din_cap = sd_datain;
			end
			if (up_palwr)
			begin
				seen_pal = 1'b1;
				pal_cap  = up_paldata;
			end
		end
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		@(negedge fclk);
		check_after(r);
		if (r.chk == CK_SDWR || r.chk == CK_SDRD)
			sd_model = sd_dataout; // every data access latches the spi byte
	endtask

	initial
	begin
		rst_n        = 1'b0;
		zpos         = 1'b1;   // every fclk is a z80 edge
		a            = 16'h0000;
		din          = 8'h00;
		iorq_n       = 1'b1;
		rd_n         = 1'b1;
		wr_n         = 1'b1;
		dos          = 1'b0;
		modes_raster = 2'd0;
		tape_read    = 1'b0;
		keys_in      = 5'h00;
		kj_in        = 8'h00;
		mus_in       = 8'h00;
		sd_dataout   = 8'h00;
		void'($urandom(63531));
		load_table();
		cycle_limit = table_q.size() * 10 + 40;
		repeat (10) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);
		check_reset();
		foreach (table_q[k])
		begin
			cur_row = k;
			apply_row(table_q[k]);
		end
		@(negedge fclk);
		if (fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/zports.sv
/*
 * zports top
 * io port block of the spectrum computer, bus strobes feeding the port registers
 */
`timescale 1ns/1ns
`default_nettype none

module zports import zports_pkg::*; (
	input  wire         fclk,
	input  wire         rst_n,
	input  wire         zpos,
	input  wire  [15:0] a,
	input  wire  [ 7:0] din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	input  wire         dos,
	input  wire  [ 1:0] modes_raster,
	input  wire         tape_read,
	input  wire  [ 4:0] keys_in,
	input  wire  [ 7:0] kj_in,
	input  wire  [ 7:0] mus_in,
	input  wire  [ 7:0] sd_dataout,
	output logic [ 7:0] dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port,
	output logic [ 3:0] border,
	output evo_cfg_t    evo_cfg,
	output atm_cfg_t    atm_cfg,
	output logic [ 7:0] p7ffd,
	output logic [ 7:0] peff7,
	output logic        pent1m_rom,
	output logic [ 5:0] pent1m_page,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        beeper_wr,
	output logic        covox_wr,
	output logic        clr_nmi,
	output logic        sd_cs_n_val,
	output logic        sd_cs_n_stb,
	output logic        sd_start,
	output logic [ 7:0] sd_datain,
	output logic        up_ena,
	output logic [ 5:0] up_paladdr,
	output logic [ 7:0] up_paldata,
	output logic        up_palwr
);

	logic       io_wr, io_rd;
	logic       shadow;
	io_req_t    req;
	logic [7:0] p7ffd_raw, peff7_raw;
	logic [7:0] sd_buf, up_last;

	bus_strobes bus_strobes_i (.fclk, .rst_n, .zpos, .iorq_n, .rd_n, .wr_n, .io_wr, .io_rd);

	port_decode port_decode_i (
		.fclk, .rst_n, .a, .din, .iorq_n, .rd_n, .io_wr, .io_rd, .dos,
		.shadow_en(evo_cfg.shadow_en), .modes_raster,
		.req, .shadow, .porthit, .external_port, .dataout
	);

	config_regs config_regs_i (
		.fclk, .rst_n, .req, .shadow, .border, .evo_cfg, .atm_cfg,
		.p7ffd_raw, .peff7_raw, .p7ffd, .peff7, .pent1m_rom, .pent1m_page,
		.pent1m_1m_on, .pent1m_ram0_0, .romrw_en, .beeper_wr, .covox_wr, .clr_nmi
	);

	ulaplus_regs ulaplus_regs_i (
		.fclk, .rst_n, .req, .up_ena, .up_paladdr, .up_paldata, .up_palwr, .up_last
	);

	sd_port sd_port_i (
		.fclk, .rst_n, .req, .sd_dataout, .sd_cs_n_val, .sd_cs_n_stb, .sd_start,
		.sd_datain, .sd_buf
	);

	read_mux read_mux_i (
		.req, .tape_read, .keys_in, .kj_in, .mus_in, .dos, .border, .evo_cfg, .atm_cfg,
		.p7ffd_raw, .peff7_raw, .sd_buf, .up_last, .dout
	);

endmodule

`default_nettype wire

// File: rtl/read_mux.sv
/*
 * z80 read data
 * value per resolved port, xxBD/xxBE readback selected by a[12:8]
 */
`timescale 1ns/1ns
`default_nettype none

`include "zports_cfg.svh"

module read_mux import zports_pkg::*; (
	input  wire io_req_t req,
	input  wire          tape_read,
	input  wire  [4:0]   keys_in,
	input  wire  [7:0]   kj_in,
	input  wire  [7:0]   mus_in,
	input  wire          dos,
	input  wire  [3:0]   border,
	input  wire evo_cfg_t evo_cfg,
	input  wire atm_cfg_t atm_cfg,
	input  wire  [7:0]   p7ffd_raw,
	input  wire  [7:0]   peff7_raw,
	input  wire  [7:0]   sd_buf,
	input  wire  [7:0]   up_last,
	output logic [7:0]   dout
);

	logic [7:0] bd_mux;

	////////////////////////////////////////////////////////////////////////////
	// readback registers
	always_comb
		case (req.a_hi[4:0])
			`ZP_BD_P7FFD:  bd_mux = p7ffd_raw;  // unmasked
			`ZP_BD_PEFF7:  bd_mux = peff7_raw;
			`ZP_BD_PXX77:  bd_mux = {~atm_cfg.pen2, atm_cfg.cpm_n, ~atm_cfg.pen, dos,
			                         atm_cfg.turbo, atm_cfg.scr_mode};
			`ZP_BD_BORDER: bd_mux = {4'h0, border};
			default:       bd_mux = 8'hFF;
		endcase

	always_comb
		case (req.sel)
			SEL_FE,
			SEL_F6:      dout = {1'b1, tape_read, 1'b0, keys_in};
			SEL_KJOY:    dout = kj_in;
			SEL_KMOUSE:  dout = mus_in;
			SEL_SDCFG:   dout = 8'h00;   // card present, writable
			SEL_SDDAT:   dout = sd_buf;
			SEL_BF:
			begin
				// bit 2 font write reads as zero
				dout = {2'b00, evo_cfg.pal444_ena, evo_cfg.brk_ena, evo_cfg.set_nmi,
				        1'b0, evo_cfg.romrw_en, evo_cfg.shadow_en};
			end
			SEL_BE,
			SEL_BD:      dout = bd_mux;
			SEL_ULAPLUS: dout = up_last;
			default:     dout = 8'hFF;   // F7, vg, ay and the rest
		endcase

endmodule

`default_nettype wire

// File: rtl/sd_port.sv
/*
 * sd card port
 * chip-select and spi start strobes, latch of the spi read byte
 */
`timescale 1ns/1ns
`default_nettype none

module sd_port import zports_pkg::*; (
	input  wire          fclk,
	input  wire          rst_n,
	input  wire io_req_t req,
	input  wire  [7:0]   sd_dataout,  // byte from spi module
	output logic         sd_cs_n_val,
	output logic         sd_cs_n_stb,
	output logic         sd_start,
	output logic [7:0]   sd_datain,
	output logic [7:0]   sd_buf       // read back on SDDAT
);

	logic dat_rd;

	assign dat_rd      = req.rd && req.sel == SEL_SDDAT;
	assign sd_cs_n_stb = req.wr && req.sel == SEL_SDCFG;
	assign sd_cs_n_val = req.data[1];
	assign sd_start    = dat_rd || (req.wr && req.sel == SEL_SDDAT); // any data access
	assign sd_datain   = dat_rd ? 8'hFF : req.data;                  // reads clock out ones

	// previous transfer result, stable through contended read cycles
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			sd_buf <= 8'hFF;
		else if (sd_start)
			sd_buf <= sd_dataout;

endmodule

`default_nettype wire

// File: regs/ulaplus_regs.sv
/*
 * ulaplus registers
 * select/data port pair, palette address, mode enable and last written byte
 */
`timescale 1ns/1ns
`default_nettype none

module ulaplus_regs import zports_pkg::*; (
	input  wire          fclk,
	input  wire          rst_n,
	input  wire io_req_t req,
	output logic         up_ena,
	output logic [5:0]   up_paladdr,
	output logic [7:0]   up_paldata,  // R3G3B2
	output logic         up_palwr,
	output logic [7:0]   up_last
);

	logic up_select; // 1 mode register, 0 palette
	logic sel_wr;    // bf3b style, a[14] low
	logic dat_wr;    // ff3b style, a[14] high

	assign sel_wr = req.wr && req.sel == SEL_ULAPLUS && !req.a_hi[6];
	assign dat_wr = req.wr && req.sel == SEL_ULAPLUS &&  req.a_hi[6];

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			up_select <= 1'b0;
		else if (sel_wr && req.data[7:6] == 2'b01)
			up_select <= 1'b1;
		else if (sel_wr && req.data[7:6] == 2'b00)
			up_select <= 1'b0;

	always_ff @(posedge fclk)
		if (sel_wr && req.data[7:6] == 2'b00)
			up_paladdr <= req.data[5:0];

	always_ff @(posedge fclk)
		if (dat_wr)
			up_last <= req.data;

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			up_ena <= 1'b0;
		else if (dat_wr && up_select)
			up_ena <= req.data[0];

	assign up_palwr   = dat_wr && !up_select;
	assign up_paldata = {req.data[4:2], req.data[7:5], req.data[1:0]}; // G3R3B2 in
endmodule

`default_nettype wire

// File: regs/config_regs.sv
/*
 * config and paging registers
 * FE border, xxBF, xx77, 7FFD and EFF7 with their locks, write-only strobes
 */
`timescale 1ns/1ns
`default_nettype none

`include "zports_cfg.svh"

module config_regs import zports_pkg::*; (
	input  wire         fclk,
	input  wire         rst_n,
	input  wire io_req_t req,
	input  wire         shadow,
	output logic [ 3:0] border,
	output evo_cfg_t    evo_cfg,
	output atm_cfg_t    atm_cfg,
	output logic [ 7:0] p7ffd_raw,
	output logic [ 7:0] peff7_raw,
	output logic [ 7:0] p7ffd,      // 1 MB lock applied
	output logic [ 7:0] peff7,
	output logic        pent1m_rom,
	output logic [ 5:0] pent1m_page,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        beeper_wr,
	output logic        covox_wr,
	output logic        clr_nmi
);

	logic border_we;
	logic block1m;    // eff7 bit 2
	logic block7ffd;  // 48k lock

	assign border_we = req.wr && (req.sel == SEL_FE || req.sel == SEL_F6);
	assign block1m   = peff7_raw[2];
	assign block7ffd = p7ffd_raw[5] & block1m;

	////////////////////////////////////////////////////////////////////////////
	// FE / F6 border, top bit is inverted a[3]
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			border <= 4'h0;
		else if (border_we)
			border <= {req.sel == SEL_F6, req.data[2:0]};

	// xxBF, bit 2 not kept
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			evo_cfg <= '0;
		else if (req.wr && req.sel == SEL_BF)
		begin
			evo_cfg.shadow_en  <= req.data[0];
			evo_cfg.romrw_en   <= req.data[1];
			evo_cfg.set_nmi    <= req.data[3];
			evo_cfg.brk_ena    <= req.data[4];
			evo_cfg.pal444_ena <= req.data[5];
		end

	// xx77, decoded only in shadow mode
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			atm_cfg <= atm_cfg_t'(`ZP_ATM77_RST);
		else if (req.wr && req.sel == SEL_ATM77)
		begin
			atm_cfg.scr_mode <= req.data[2:0];
			atm_cfg.turbo    <= req.data[3];
			atm_cfg.pen      <= ~req.a_hi[0];  // a[8]
			atm_cfg.cpm_n    <=  req.a_hi[1];  // a[9]
			atm_cfg.pen2     <= ~req.a_hi[6];  // a[14]
		end

	////////////////////////////////////////////////////////////////////////////
	// paging
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			p7ffd_raw <= 8'h00;
		else if (req.wr && req.sel == SEL_7FFD && !block7ffd)
			p7ffd_raw <= req.data; // 2..0 page, 3 screen, 4 rom, 5 lock48k, 7..6 hi page

	// eef7 is not writable in shadow mode
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			peff7_raw <= 8'h00;
		else if (req.wr && req.sel == SEL_EFF7 && !req.a_hi[4] && !shadow)
			peff7_raw <= req.data; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off

	assign p7ffd = {block1m ? 3'b000 : p7ffd_raw[7:5], p7ffd_raw[4:0]};
	assign peff7 = block1m ? {peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]}
	                       : peff7_raw;

	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];
	assign romrw_en      = evo_cfg.romrw_en;

	// strobes, same cycle as the bus pulse
	assign beeper_wr = req.wr && req.sel == SEL_FE;
	assign covox_wr  = req.wr && req.sel == SEL_COVOX;
	assign clr_nmi   = req.wr && req.sel == SEL_BE;

	// every beeper write also lands in the border register
	a_beeper_border: assert property (@(posedge fclk) disable iff (!rst_n)
		beeper_wr |-> border_we ##1 (border[2:0] == $past(req.data[2:0])));

endmodule

`default_nettype wire

// File: rtl/port_decode.sv
/*
 * io port decoder
 * low address byte plus shadow mode to one port select, porthit and external_port
 */
`timescale 1ns/1ns
`default_nettype none

`include "zports_cfg.svh"

module port_decode import zports_pkg::*; (
	input  wire         fclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [ 7:0] din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         io_wr,
	input  wire         io_rd,
	input  wire         dos,
	input  wire         shadow_en,     // bit 0 of xxBF
	input  wire  [ 1:0] modes_raster,
	output io_req_t     req,
	output logic        shadow,
	output logic        porthit,       // internal port, keeps the zxbus off
	output logic        external_port, // AY and VG93
	output logic        dataout        // we drive the z80 data bus
);

	logic [7:0] loa;
	logic       up_ports;   // ulaplus visible
	port_sel_e  sel;

	assign loa      = a[7:0];
	assign shadow   = dos | shadow_en;
	assign up_ports = (modes_raster == `ZP_RASTER_128K);

	////////////////////////////////////////////////////////////////////////////
	// port resolution
	always_comb
	begin
		sel = SEL_NONE;
		if (loa == `ZP_FE)
			sel = SEL_FE;
		else if (loa == `ZP_F6)
			sel = SEL_F6;
		else if (loa == `ZP_FD)
			sel = a[15] ? SEL_AY : SEL_7FFD;
		else if (loa == `ZP_F7)
			sel = (a[8] ^ shadow) ? SEL_EFF7 : SEL_F7_OTHER; // EEF7 style in shadow
		else if (loa == `ZP_KJOY && !shadow)
			sel = SEL_KJOY;
		else if ((loa == `ZP_VGCOM || loa == `ZP_VGTRK ||
		          loa == `ZP_VGSEC || loa == `ZP_VGDAT) && shadow)
			sel = SEL_VG;
		else if (loa == `ZP_VGSYS && shadow)
			sel = SEL_VGSYS;
		else if (loa == `ZP_KMOUSE)
			sel = SEL_KMOUSE;
		else if (loa == `ZP_SDCFG && !shadow)
			sel = SEL_SDCFG;
		else if (loa == `ZP_ATM77 && shadow)
			sel = SEL_ATM77;
		else if (loa == `ZP_SDDAT)
			sel = (shadow && a[15]) ? SEL_SDCFG : SEL_SDDAT; // cfg moves here in dos
		else if (loa == `ZP_BF)
			sel = SEL_BF;
		else if (loa == `ZP_BE)
			sel = SEL_BE;
		else if (loa == `ZP_BD)
			sel = SEL_BD;
		else if (loa == `ZP_FB)
			sel = SEL_COVOX;
		else if (loa == `ZP_ULAPLUS && up_ports)
			sel = SEL_ULAPLUS;
	end

	// covox is write only and left to the bus
	assign porthit       = (sel != SEL_NONE) && (sel != SEL_COVOX);
	assign external_port = (sel == SEL_AY) || (sel == SEL_VG);
	assign dataout       = porthit & ~iorq_n & ~rd_n & ~external_port;

	assign req.sel  = sel;
	assign req.wr   = io_wr;
	assign req.rd   = io_rd;
	assign req.a_hi = a[15:8];
	assign req.data = din;

	a_hit_has_sel: assert property (@(posedge fclk) disable iff (!rst_n)
		porthit |-> (req.sel != SEL_NONE));

endmodule

`default_nettype wire

// File: rtl/bus_strobes.sv
/*
 * z80 io bus strobes
 * samples iorq_n/rd_n/wr_n on zpos, one fclk pulse per read or write cycle
 */
`timescale 1ns/1ns
`default_nettype none

module bus_strobes (
	input  wire  fclk,
	input  wire  rst_n,
	input  wire  zpos,    // z80 rising edge qualifier
	input  wire  iorq_n,
	input  wire  rd_n,
	input  wire  wr_n,
	output logic io_wr,   // single cycle
	output logic io_rd    // single cycle
);

	logic [1:0] wr_smp; // [0] zpos sample, [1] delayed copy
	logic [1:0] rd_smp;

	// first stage only moves on zpos
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			wr_smp[0] <= 1'b0;
			rd_smp[0] <= 1'b0;
		end
		else if (zpos)
		begin
			wr_smp[0] <= ~(iorq_n | wr_n);
			rd_smp[0] <= ~(iorq_n | rd_n);
		end

	// second stage and edge detect every fclk
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			wr_smp[1] <= 1'b0;
			rd_smp[1] <= 1'b0;
			io_wr     <= 1'b0;
			io_rd     <= 1'b0;
		end
		else
		begin
			wr_smp[1] <= wr_smp[0];
			rd_smp[1] <= rd_smp[0];
			io_wr     <= wr_smp[0] & ~wr_smp[1]; // rising edge only
			io_rd     <= rd_smp[0] & ~rd_smp[1];
		end

	// z80 never reads and writes in one cycle, pulses never stretch
	a_no_overlap: assert property (@(posedge fclk) disable iff (!rst_n)
		!(io_wr && io_rd));
	a_single_pulse: assert property (@(posedge fclk) disable iff (!rst_n)
		(io_wr |=> !io_wr) and (io_rd |=> !io_rd));

endmodule

`default_nettype wire

// File: common/zports_pkg.sv
/*
 * zports types
 * resolved port select and the structs passed between the port blocks
 */
`default_nettype none

package zports_pkg;

	// one value per resolved port, address and shadow mode already applied
	typedef enum logic [4:0]
	{
		SEL_NONE,
		SEL_FE,
		SEL_F6,
		SEL_7FFD,
		SEL_AY,        // BFFD / FFFD
		SEL_EFF7,
		SEL_F7_OTHER,  // any other xxF7
		SEL_KJOY,
		SEL_VG,        // 1F 3F 5F 7F in shadow mode
		SEL_VGSYS,
		SEL_KMOUSE,
		SEL_SDCFG,
		SEL_SDDAT,
		SEL_ATM77,
		SEL_BF,
		SEL_BE,
		SEL_BD,
		SEL_COVOX,
		SEL_ULAPLUS
	} port_sel_e;

	// decoded bus cycle
	typedef struct packed
	{
		port_sel_e  sel;
		logic       wr;    // one fclk pulse
		logic       rd;    // one fclk pulse
		logic [7:0] a_hi;  // a[15:8]
		logic [7:0] data;  // din
	} io_req_t;

	// xx77 register
	typedef struct packed
	{
		logic [2:0] scr_mode;
		logic       turbo;
		logic       pen;    // not inverted
		logic       cpm_n;
		logic       pen2;   // not inverted
	} atm_cfg_t;

	// xxBF register
	typedef struct packed
	{
		logic shadow_en;
		logic romrw_en;
		logic set_nmi;
		logic brk_ena;
		logic pal444_ena;
	} evo_cfg_t;

endpackage

`default_nettype wire

// File: common/zports_cfg.svh
/*
 * zports port map
 * low address bytes, xxBD readback sub-addresses and reset values
 */
`ifndef ZPORTS_CFG_SVH
`define ZPORTS_CFG_SVH

// low address byte of each port
`define ZP_FE      8'hFE      // border, beeper, keyboard
`define ZP_F6      8'hF6      // FE alias with a[3] low
`define ZP_F7      8'hF7
`define ZP_FD      8'hFD      // 7FFD paging and AY
`define ZP_FB      8'hFB      // covox
`define ZP_KJOY    8'h1F      // kempston joystick
`define ZP_VGSYS   8'hFF
`define ZP_VGCOM   8'h1F
`define ZP_VGTRK   8'h3F
`define ZP_VGSEC   8'h5F
`define ZP_VGDAT   8'h7F
`define ZP_KMOUSE  8'hDF
`define ZP_SDCFG   8'h77
`define ZP_SDDAT   8'h57
`define ZP_ATM77   8'h77
`define ZP_BF      8'hBF      // evo config
`define ZP_BE      8'hBE      // nmi end, readback
`define ZP_BD      8'hBD      // readback
`define ZP_ULAPLUS 8'h3B

// xxBD / xxBE readback, selected by a[12:8]
`define ZP_BD_P7FFD  5'h0A
`define ZP_BD_PEFF7  5'h0B
`define ZP_BD_PXX77  5'h0C
`define ZP_BD_BORDER 5'h0F

// scr_mode 011, turbo 0, pen 1, cpm_n 0, pen2 0
`define ZP_ATM77_RST 7'b0110100

`define ZP_RASTER_128K 2'b11  // ulaplus only with this raster

`endif
